// File: oflow_core_config.svh
/* oflow core configuration */

`ifndef OFLOW_CORE_CONFIG_SVH
`define OFLOW_CORE_CONFIG_SVH

// ----------------------------------------------------------
// data widths
// ----------------------------------------------------------
`define SCORE_LEN                  8  // match score
`define ID_LEN                     6  // track id, 64 lut entries
`define NUM_OF_BBOX_IN_FRAME_WIDTH 6  // bbox count of a frame

// ----------------------------------------------------------
// score board geometry
// ----------------------------------------------------------
`define ROW_LEN  3 // row index
`define NUM_ROWS 8 // new-frame bboxes
`define PE_LEN   1 // best match and fallback

// ----------------------------------------------------------
// conflict limit
// ----------------------------------------------------------
`define MAX_CONFLICTS_TH 16 // stop the run here
`define CONFLICT_CNT_LEN 5  // wide enough to hold the limit

`endif

// File: oflow_core_pkg.sv
/* oflow core types */

`default_nettype none

`include "oflow_core_config.svh"

package oflow_core_pkg;

	// scores coming from the pe array
	typedef logic [`SCORE_LEN-1:0] score_t;

	typedef logic [`ID_LEN-1:0] id_t;       // previous-frame track id
	typedef logic [`ROW_LEN-1:0] row_t;     // score board row
	typedef logic [`PE_LEN-1:0] pe_t;       // candidate slot, 0 best, 1 fallback

	// bbox totals per frame
	typedef logic [`NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] bbox_cnt_t;

	// lut content, owning row on top and owning score below
	typedef logic [`ROW_LEN+`SCORE_LEN-1:0] lut_word_t;

endpackage

`default_nettype wire

// File: oflow_cr_pkg.sv
/* conflict resolver types */

`default_nettype none

package oflow_cr_pkg;

	// resolver states
	typedef enum logic [3:0] {
		IDLE,       // waiting for start_cr
		CLEAR,      // counters and resolved rows back to zero
		READ_ROW,   // fetch the row pointer
		WAIT_SB,    // candidate score and id, lut address out
		READ_LUT,   // lut word and flag come back
		DECIDE,     // threshold, claim, win or lose
		FIX_LOSER,  // move the row that lost its id
		NEXT_ROW,   // end of a pass
		WRITE_IDS,  // final ids into the score board
		DONE        // done_cr pulse
	} cr_state_t;

	// claimed marker, one per id
	typedef logic flag_t;

endpackage

`default_nettype wire

// File: oflow_score_board_if.sv
/* score board link */

`timescale 1ns/1ns
`default_nettype none

interface oflow_score_board_if
	import oflow_core_pkg::*;
();

	// read side, data comes back in the same cycle
	row_t   row_sel;
	pe_t    pe_sel;
	score_t score_to_cr;
	id_t    id_to_cr;
	pe_t    pointer_to_cr;  // pointer of row_sel

	// pointer write, one-cycle strobe
	row_t   row_to_change;
	pe_t    pe_to_change;   // slot the row is leaving
	pe_t    data_to_score_board_from_cr_pointer;
	logic   write_to_pointer;

	// final id write, same row_to_change
	id_t    data_to_score_board_from_cr_id;
	logic   write_to_id;

	logic   cr_busy;        // high while a run is in progress, blocks loads

	modport cr (
		output row_sel, pe_sel,
		output row_to_change, pe_to_change,
		output data_to_score_board_from_cr_pointer, write_to_pointer,
		output data_to_score_board_from_cr_id, write_to_id,
		output cr_busy,
		input  score_to_cr, id_to_cr, pointer_to_cr
	);

	modport sb (
		input  row_sel, pe_sel,
		input  row_to_change, pe_to_change,
		input  data_to_score_board_from_cr_pointer, write_to_pointer,
		input  data_to_score_board_from_cr_id, write_to_id,
		input  cr_busy,
		output score_to_cr, id_to_cr, pointer_to_cr
	);

endinterface

`default_nettype wire

// File: oflow_lut_ram.sv
/* id lut ram */

`timescale 1ns/1ns
`default_nettype none

`include "oflow_core_config.svh"

module oflow_lut_ram
	import oflow_core_pkg::*;
(
	input  logic      clk,
	input  logic      we,     // write port
	input  id_t       waddr,
	input  lut_word_t wdata,
	input  logic      re,     // read port
	input  id_t       raddr,
	output lut_word_t rdata
);

	// one word per track id
	lut_word_t mem [(1 << `ID_LEN)];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		if (re) begin
			rdata <= mem[raddr]; // one cycle read latency
		end
	end

endmodule

`default_nettype wire

// File: oflow_score_board.sv
/* score board rows */

`timescale 1ns/1ns
`default_nettype none

`include "oflow_core_config.svh"

module oflow_score_board
	import oflow_core_pkg::*;
(
	input  logic   clk,
	input  logic   reset_N,
	oflow_score_board_if.sb sb,
	input  logic   load_en,
	input  row_t   load_row,
	input  pe_t    load_pe,
	input  score_t load_score,
	input  id_t    load_id,
	input  row_t   rd_row,
	output id_t    rd_id,
	output pe_t    rd_pointer
);

	score_t cand_score [`NUM_ROWS][(1 << `PE_LEN)];
	id_t    cand_id    [`NUM_ROWS][(1 << `PE_LEN)];
	id_t    final_id   [`NUM_ROWS];
	pe_t    pointer    [`NUM_ROWS]; // slot in use per row
	logic   load_ok;

	assign load_ok = load_en && !sb.cr_busy; // no loads during a run

	// ----------------------------------------------------------
	// pointers
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int r = 0; r < `NUM_ROWS; r++) begin
				pointer[r] <= '0;
			end
		end else if (load_ok) begin
			pointer[load_row] <= '0; // fresh candidates start on the best match
		end else if (sb.write_to_pointer &&
				pointer[sb.row_to_change] == sb.pe_to_change) begin
			pointer[sb.row_to_change] <= sb.data_to_score_board_from_cr_pointer;
		end
	end

	// candidates from the loader, final ids from the resolver
	always_ff @(posedge clk) begin
		if (load_ok) begin
			cand_score[load_row][load_pe] <= load_score;
			cand_id[load_row][load_pe]    <= load_id;
		end
		if (sb.write_to_id) begin
			final_id[sb.row_to_change] <= sb.data_to_score_board_from_cr_id;
		end
	end

	// ----------------------------------------------------------
	// combinational reads
	// ----------------------------------------------------------
	assign sb.score_to_cr   = cand_score[sb.row_sel][sb.pe_sel];
	assign sb.id_to_cr      = cand_id[sb.row_sel][sb.pe_sel];
	assign sb.pointer_to_cr = pointer[sb.row_sel];

	assign rd_id      = final_id[rd_row]; // readback port
	assign rd_pointer = pointer[rd_row];

endmodule

`default_nettype wire

// File: oflow_conflict_resolve_fsm.sv
/* conflict resolve state machine */

`timescale 1ns/1ns
`default_nettype none

`include "oflow_core_config.svh"

module oflow_conflict_resolve_fsm
	import oflow_core_pkg::*;
	import oflow_cr_pkg::*;
(
	input  logic      clk,
	input  logic      reset_N,
	input  logic      start_cr,
	output logic      done_cr,
	input  score_t    score_th_for_new_bbox,
	input  logic      initial_counter_for_new_bbox,
	input  bbox_cnt_t total_bboxes_first_frame,
	output id_t       address_lut,
	output lut_word_t data_in_lut,
	output logic      we_lut,
	input  lut_word_t data_out_lut_for_fsm,
	input  flag_t     data_out_flag,
	output id_t       address_flag,
	output flag_t     data_in_flag,
	oflow_score_board_if.cr sb,
	output logic      conflict_counter_th
);

	cr_state_t state;
	row_t      row;         // row under test, also the write-back index
	pe_t       cur_pe;      // pointer of that row
	score_t    cur_score;
	id_t       cur_id;
	row_t      owner_row;   // from the lut, loser in FIX_LOSER
	score_t    owner_score;
	flag_t     claimed;
	id_t       new_id_cnt;  // next fresh id
	logic [`NUM_ROWS-1:0] resolved;  // rows that already got a fresh id
	logic [`CONFLICT_CNT_LEN-1:0] conflict_cnt;
	logic      changed;     // something moved during this pass

	logic last_row, limit_hit, below_th, own_row, wins;
	logic cur_on_fb, loser_on_fb, fresh_id;

	// ----------------------------------------------------------
	// decision terms
	// ----------------------------------------------------------
	assign last_row    = (row == row_t'(`NUM_ROWS-1));
	assign limit_hit   = (conflict_cnt >= `CONFLICT_CNT_LEN'(`MAX_CONFLICTS_TH));
	assign below_th    = (cur_score < score_th_for_new_bbox);
	assign own_row     = claimed && (owner_row == row);      // row already holds it
	assign wins        = claimed && !own_row && !below_th &&
		(cur_score > owner_score);                           // strictly higher only
	assign cur_on_fb   = (cur_pe == pe_t'(1));
	assign loser_on_fb = (sb.pointer_to_cr == pe_t'(1));     // valid in FIX_LOSER
	assign fresh_id    = sb.write_to_id && (state != WRITE_IDS);

	// ----------------------------------------------------------
	// score board and lut addressing
	// ----------------------------------------------------------
	assign sb.row_sel       = (state == FIX_LOSER) ? owner_row : row;
	assign sb.row_to_change = (state == FIX_LOSER) ? owner_row : row;
	assign sb.pe_sel        = (state == WRITE_IDS) ? sb.pointer_to_cr : cur_pe;
	assign sb.pe_to_change  = (state == FIX_LOSER) ? sb.pointer_to_cr : cur_pe;
	assign sb.data_to_score_board_from_cr_pointer = pe_t'(1); // only move is to the fallback
	assign sb.cr_busy       = (state != IDLE);

	assign address_lut  = (state == WAIT_SB) ? sb.id_to_cr : cur_id; // read, then write
	assign data_in_lut  = {row, cur_score};  // new owner
	assign address_flag = cur_id;
	assign data_in_flag = 1'b1;              // each lut write claims the id
	assign done_cr      = (state == DONE);

	// strobes per state
	always_comb begin
		sb.write_to_pointer = 1'b0;
		sb.write_to_id = 1'b0;
		sb.data_to_score_board_from_cr_id = new_id_cnt;
		we_lut = 1'b0;
		case (state)
			DECIDE: begin
				if (below_th) begin
					sb.write_to_id = 1'b1;           // no usable match
				end else if (!claimed || wins) begin
					we_lut = 1'b1;                   // claim or take over
				end else if (!own_row) begin
					sb.write_to_id = cur_on_fb;      // lost the fallback too
					sb.write_to_pointer = !cur_on_fb;
				end
			end
			FIX_LOSER: begin
				sb.write_to_id = loser_on_fb;
				sb.write_to_pointer = !loser_on_fb;
			end
			WRITE_IDS: begin
				sb.data_to_score_board_from_cr_id = sb.id_to_cr; // id at the pointer
				sb.write_to_id = !resolved[row];
			end
			default: begin
			end
		endcase
	end

	// ----------------------------------------------------------
	// control state
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= IDLE;
			row <= '0;
			resolved <= '0;
			changed <= 1'b0;
			conflict_cnt <= '0;
			new_id_cnt <= '0;
			conflict_counter_th <= 1'b0;
		end else begin
			if (initial_counter_for_new_bbox) begin
				new_id_cnt <= id_t'(total_bboxes_first_frame);
			end else if (fresh_id) begin
				new_id_cnt <= new_id_cnt + 1'b1;
			end
			if (fresh_id) begin
				resolved[sb.row_to_change] <= 1'b1;
			end

			case (state)
				IDLE: begin
					if (start_cr) state <= CLEAR;
				end
				CLEAR: begin
					row <= '0;
					resolved <= '0;
					changed <= 1'b0;
					conflict_cnt <= '0;
					conflict_counter_th <= 1'b0;
					state <= READ_ROW;
				end
				READ_ROW: begin
					if (limit_hit) begin
						conflict_counter_th <= 1'b1;
						row <= '0;
						state <= WRITE_IDS;
					end else if (resolved[row]) begin
						row <= row + 1'b1;           // nothing left to do here
						state <= last_row ? NEXT_ROW : READ_ROW;
					end else begin
						state <= WAIT_SB;
					end
				end
				WAIT_SB:  state <= READ_LUT;
				READ_LUT: state <= DECIDE;
				DECIDE: begin
					if (below_th || !claimed) begin
						changed <= 1'b1;
					end else if (!own_row) begin
						changed <= 1'b1;
						conflict_cnt <= conflict_cnt + 1'b1;
					end
					if (wins) begin
						state <= FIX_LOSER;
					end else begin
						row <= row + 1'b1;
						state <= last_row ? NEXT_ROW : READ_ROW;
					end
				end
				FIX_LOSER: begin
					row <= row + 1'b1;
					state <= last_row ? NEXT_ROW : READ_ROW;
				end
				NEXT_ROW: begin
					row <= '0;
					changed <= 1'b0;
					if (limit_hit) begin
						conflict_counter_th <= 1'b1;
						state <= WRITE_IDS;
					end else begin
						state <= changed ? READ_ROW : WRITE_IDS; // quiet pass ends it
					end
				end
				WRITE_IDS: begin
					row <= row + 1'b1;
					if (last_row) state <= DONE;
				end
				DONE:    state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// captured candidate and lut word
	always_ff @(posedge clk) begin
		case (state)
			READ_ROW: cur_pe <= sb.pointer_to_cr;
			WAIT_SB: begin
				cur_score <= sb.score_to_cr;
				cur_id <= sb.id_to_cr;
			end
			READ_LUT: begin
				owner_row <= data_out_lut_for_fsm[`ROW_LEN+`SCORE_LEN-1:`SCORE_LEN];
				owner_score <= data_out_lut_for_fsm[`SCORE_LEN-1:0];
				claimed <= data_out_flag;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: oflow_conflict_resolve.sv
/* conflict resolver */

`timescale 1ns/1ns
`default_nettype none

`include "oflow_core_config.svh"

module oflow_conflict_resolve
	import oflow_core_pkg::*;
	import oflow_cr_pkg::*;
(
	input  logic      clk,
	input  logic      reset_N,
	input  logic      start_cr,
	output logic      done_cr,
	input  score_t    score_th_for_new_bbox,
	input  logic      initial_counter_for_new_bbox,
	input  bbox_cnt_t total_bboxes_first_frame,
	oflow_score_board_if.cr sb,
	output logic      conflict_counter_th
);

	// lut side
	id_t       address_lut;
	lut_word_t data_in_lut;
	lut_word_t data_out_lut_for_fsm;
	logic      we_lut;

	// flag side
	id_t       address_flag;
	flag_t     data_in_flag;
	flag_t     data_out_flag;
	flag_t     flag_reg [(1 << `ID_LEN)];

	assign data_out_flag = flag_reg[address_flag]; // no read latency

	// ----------------------------------------------------------
	// claimed flags, wiped at each accepted start
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int i = 0; i < (1 << `ID_LEN); i++) begin
				flag_reg[i] <= '0;
			end
		end else if (start_cr && !sb.cr_busy) begin
			for (int i = 0; i < (1 << `ID_LEN); i++) begin
				flag_reg[i] <= '0;
			end
		end else if (we_lut) begin
			flag_reg[address_flag] <= data_in_flag; // follows every lut write
		end
	end

	oflow_conflict_resolve_fsm u_fsm (
		.clk                          (clk),
		.reset_N                      (reset_N),
		.start_cr                     (start_cr),
		.done_cr                      (done_cr),
		.score_th_for_new_bbox        (score_th_for_new_bbox),
		.initial_counter_for_new_bbox (initial_counter_for_new_bbox),
		.total_bboxes_first_frame     (total_bboxes_first_frame),
		.address_lut                  (address_lut),
		.data_in_lut                  (data_in_lut),
		.we_lut                       (we_lut),
		.data_out_lut_for_fsm         (data_out_lut_for_fsm),
		.data_out_flag                (data_out_flag),
		.address_flag                 (address_flag),
		.data_in_flag                 (data_in_flag),
		.sb                           (sb),
		.conflict_counter_th          (conflict_counter_th)
	);

	// same address on both ports, read only when not writing
	oflow_lut_ram u_lut (
		.clk   (clk),
		.we    (we_lut),
		.waddr (address_lut),
		.wdata (data_in_lut),
		.re    (~we_lut),
		.raddr (address_lut),
		.rdata (data_out_lut_for_fsm)
	);

endmodule

`default_nettype wire

// File: oflow_cr_top.sv
/* conflict resolve top */

`timescale 1ns/1ns
`default_nettype none

module oflow_cr_top
	import oflow_core_pkg::*;
(
	input  logic      clk,
	input  logic      reset_N,
	// candidate loader
	input  logic      load_en,
	input  row_t      load_row,
	input  pe_t       load_pe,
	input  score_t    load_score,
	input  id_t       load_id,
	// run control
	input  logic      start_cr,
	input  score_t    score_th_for_new_bbox,
	input  logic      initial_counter_for_new_bbox,
	input  bbox_cnt_t total_bboxes_first_frame,
	output logic      done_cr,
	output logic      conflict_counter_th,
	// readback
	input  row_t      rd_row,
	output id_t       rd_id,
	output pe_t       rd_pointer
);

	oflow_score_board_if sb_if ();

	oflow_score_board u_score_board (
		.clk        (clk),
		.reset_N    (reset_N),
		.sb         (sb_if.sb),
		.load_en    (load_en),
		.load_row   (load_row),
		.load_pe    (load_pe),
		.load_score (load_score),
		.load_id    (load_id),
		.rd_row     (rd_row),
		.rd_id      (rd_id),
		.rd_pointer (rd_pointer)
	);

	oflow_conflict_resolve u_cr (
		.clk                          (clk),
		.reset_N                      (reset_N),
		.start_cr                     (start_cr),
		.done_cr                      (done_cr),
		.score_th_for_new_bbox        (score_th_for_new_bbox),
		.initial_counter_for_new_bbox (initial_counter_for_new_bbox),
		.total_bboxes_first_frame     (total_bboxes_first_frame),
		.sb                           (sb_if.cr),
		.conflict_counter_th          (conflict_counter_th)
	);

endmodule

`default_nettype wire

// File: oflow_cr_tb.sv
/* conflict resolver testbench */

`timescale 1ns/1ns
`default_nettype none

`include "oflow_core_config.svh"

module oflow_cr_tb
	import oflow_core_pkg::*;
();

	localparam int NUM_TESTS     = 6;
	localparam int RANDOM_FRAMES = 6;
	localparam int NUM_RUNS      = 6 + RANDOM_FRAMES;  // shared_id makes two runs
	localparam int RUN_BOUND     = `NUM_ROWS * `NUM_ROWS * 6 + `NUM_ROWS; // cycles
	localparam int WATCHDOG_NS   = NUM_RUNS * RUN_BOUND * 20;

	logic      clk;
	logic      reset_N;
	logic      load_en;
	row_t      load_row;
	pe_t       load_pe;
	score_t    load_score;
	id_t       load_id;
	logic      start_cr;
	score_t    score_th_for_new_bbox;
	logic      initial_counter_for_new_bbox;
	bbox_cnt_t total_bboxes_first_frame;
	logic      done_cr;
	logic      conflict_counter_th;
	row_t      rd_row;
	id_t       rd_id;
	pe_t       rd_pointer;

	// frame under test and expected results
	int frame_score [`NUM_ROWS][2];
	int frame_id    [`NUM_ROWS][2];
	int exp_id      [`NUM_ROWS];
	int exp_ptr     [`NUM_ROWS];
	bit exp_limit;
	int exp_conflicts;
	int th;            // new-bbox threshold
	int base;          // first-frame bbox total
	int seed = 96308;
	int checks = 0;
	int errors = 0;

	oflow_cr_top uut (
		.clk                          (clk),
		.reset_N                      (reset_N),
		.load_en                      (load_en),
		.load_row                     (load_row),
		.load_pe                      (load_pe),
		.load_score                   (load_score),
		.load_id                      (load_id),
		.start_cr                     (start_cr),
		.score_th_for_new_bbox        (score_th_for_new_bbox),
		.initial_counter_for_new_bbox (initial_counter_for_new_bbox),
		.total_bboxes_first_frame     (total_bboxes_first_frame),
		.done_cr                      (done_cr),
		.conflict_counter_th          (conflict_counter_th),
		.rd_row                       (rd_row),
		.rd_id                        (rd_id),
		.rd_pointer                   (rd_pointer)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // 20 ns period
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the tests ran far longer than their bound");
		$display("Result: FAILED");
		$finish;
	end

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------
	task automatic check_value(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before, input string note);
		if (errors == err_before) $display("test %s: ok %s", name, note);
		else $display("test %s: %0d errors %s", name, errors - err_before, note);
	endtask

	// distinct ids and scores well above threshold
	task automatic set_base_frame();
		th = 50;
		base = 20;
		for (int r = 0; r < `NUM_ROWS; r++) begin
			frame_id[r][0] = 40 + r;
			frame_id[r][1] = 50 + r;
			frame_score[r][0] = 200;
			frame_score[r][1] = 150;
		end
	endtask

	// reference rule over ascending rows and repeated passes
	task automatic model_resolve();
		int ptr [`NUM_ROWS];
		bit fixed [`NUM_ROWS];        // row holds a fresh id
		bit flag [(1 << `ID_LEN)];
		int owner [(1 << `ID_LEN)];
		int owner_score [(1 << `ID_LEN)];
		int next_id;
		int s;
		int i;
		int loser;
		bit changed;
		next_id = base;
		exp_conflicts = 0;
		exp_limit = 1'b0;
		for (int r = 0; r < `NUM_ROWS; r++) begin
			ptr[r] = 0;
			fixed[r] = 1'b0;
		end
		for (int k = 0; k < (1 << `ID_LEN); k++) flag[k] = 1'b0;
		do begin
			changed = 1'b0;
			for (int r = 0; r < `NUM_ROWS && !exp_limit; r++) begin
				if (exp_conflicts >= `MAX_CONFLICTS_TH) begin
					exp_limit = 1'b1;
				end else if (!fixed[r]) begin
					s = frame_score[r][ptr[r]];
					i = frame_id[r][ptr[r]];
					if (s < th) begin
						exp_id[r] = next_id % (1 << `ID_LEN);
						next_id++;
						fixed[r] = 1'b1;
						changed = 1'b1;
					end else if (!flag[i]) begin
						flag[i] = 1'b1;   // first claim
						owner[i] = r;
						owner_score[i] = s;
						changed = 1'b1;
					end else if (owner[i] != r) begin
						changed = 1'b1;
						exp_conflicts++;
						if (s > owner_score[i]) begin
							loser = owner[i];   // strictly higher takes it
							owner[i] = r;
							owner_score[i] = s;
						end else begin
							loser = r;          // tie keeps the earlier owner
						end
						if (ptr[loser] == 1) begin
							exp_id[loser] = next_id % (1 << `ID_LEN);
							next_id++;
							fixed[loser] = 1'b1;
						end else begin
							ptr[loser] = 1;
						end
					end
				end
			end
			if (exp_conflicts >= `MAX_CONFLICTS_TH) exp_limit = 1'b1;
		end while (changed && !exp_limit);
		for (int r = 0; r < `NUM_ROWS; r++) begin
			exp_ptr[r] = ptr[r];
			if (!fixed[r]) exp_id[r] = frame_id[r][ptr[r]];
		end
	endtask

	// ----------------------------------------------------------
	// DUT access
	// ----------------------------------------------------------
	task automatic load_frame();
		for (int r = 0; r < `NUM_ROWS; r++) begin
			for (int p = 0; p < 2; p++) begin
				@(posedge clk);
				load_en <= 1'b1;
				load_row <= row_t'(r);
				load_pe <= pe_t'(p);
				load_score <= score_t'(frame_score[r][p]);
				load_id <= id_t'(frame_id[r][p]);
			end
		end
		@(posedge clk);
		load_en <= 1'b0;
	endtask

	task automatic run_resolver();
		int cycles;
		cycles = 0;
		@(posedge clk);
		score_th_for_new_bbox <= score_t'(th);
		total_bboxes_first_frame <= bbox_cnt_t'(base);
		initial_counter_for_new_bbox <= 1'b1;   // fresh ids restart at base
		@(posedge clk);
		initial_counter_for_new_bbox <= 1'b0;
		start_cr <= 1'b1;
		@(posedge clk);
		start_cr <= 1'b0;
		@(negedge clk);
		while (!done_cr && cycles < RUN_BOUND) begin
			@(negedge clk);
			cycles++;
		end
		if (!done_cr) begin
			$display("done_cr did not rise within %0d cycles of start_cr", RUN_BOUND);
			errors++;
		end else begin
			@(negedge clk);
			check_value("done_cr", int'(done_cr), 0);   // one-cycle pulse
		end
	endtask

	task automatic compare_rows();
		for (int r = 0; r < `NUM_ROWS; r++) begin
			@(posedge clk);
			rd_row <= row_t'(r);
			@(negedge clk);   // readback is combinational
			check_value($sformatf("rd_id[%0d]", r), int'(rd_id), exp_id[r]);
			check_value($sformatf("rd_pointer[%0d]", r), int'(rd_pointer), exp_ptr[r]);
		end
		check_value("conflict_counter_th", int'(conflict_counter_th), int'(exp_limit));
	endtask

	task automatic execute_frame();
		load_frame();
		model_resolve();
		run_resolver();
		compare_rows();
	endtask

	// ----------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------
	task automatic no_conflict();
		int err_before;
		err_before = errors;
		@(negedge clk);
		check_value("done_cr", int'(done_cr), 0);   // quiet after reset
		check_value("conflict_counter_th", int'(conflict_counter_th), 0);
		set_base_frame();
		execute_frame();
		report_test("no_conflict", err_before, "");
	endtask

	task automatic shared_id();
		int err_before;
		err_before = errors;
		set_base_frame();
		frame_id[0][0] = 5;
		frame_score[0][0] = 100;
		frame_id[0][1] = 9;
		frame_score[0][1] = 90;
		frame_id[3][0] = 5;
		frame_score[3][0] = 150;   // later row with higher score
		frame_id[3][1] = 12;
		execute_frame();
		frame_score[3][0] = 100;   // tie now
		execute_frame();
		report_test("shared_id", err_before, "");
	endtask

	task automatic below_threshold();
		int err_before;
		err_before = errors;
		set_base_frame();
		frame_score[2][0] = 10;
		frame_score[5][0] = 49;   // one under
		frame_score[6][0] = 50;   // exactly at threshold so kept
		execute_frame();
		report_test("below_threshold", err_before, "");
	endtask

	task automatic fallback_lost();
		int err_before;
		err_before = errors;
		set_base_frame();
		frame_id[0][0] = 3;
		frame_id[1][0] = 3;
		frame_score[1][0] = 100;
		frame_id[1][1] = 4;
		frame_score[1][1] = 60;
		frame_id[2][0] = 4;
		frame_score[2][0] = 180;  // holds the fallback of row 1
		execute_frame();
		report_test("fallback_lost", err_before, "");
	endtask

	// every row fights for one id with rising scores
	task automatic conflict_chain();
		int err_before;
		err_before = errors;
		set_base_frame();
		for (int r = 0; r < `NUM_ROWS; r++) begin
			frame_id[r][0] = 1;
			frame_id[r][1] = 1;
			frame_score[r][0] = 100 + r;
			frame_score[r][1] = 200 + r;
		end
		execute_frame();
		report_test("conflict_chain", err_before,
			$sformatf("(model conflicts %0d, limit %0d)", exp_conflicts, `MAX_CONFLICTS_TH));
	endtask

	task automatic random_frames();
		int err_before;
		err_before = errors;
		for (int f = 0; f < RANDOM_FRAMES; f++) begin
			th = 30 + {$random(seed)} % 40;
			base = 16 + f;
			for (int r = 0; r < `NUM_ROWS; r++) begin
				for (int p = 0; p < 2; p++) begin
					frame_score[r][p] = {$random(seed)} % 256;
					frame_id[r][p] = {$random(seed)} % 4;   // small range for many clashes
				end
			end
			execute_frame();
		end
		report_test("random_frames", err_before, "");
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial begin
		reset_N = 1'b0;
		load_en = 1'b0;
		load_row = '0;
		load_pe = '0;
		load_score = '0;
		load_id = '0;
		start_cr = 1'b0;
		score_th_for_new_bbox = '0;
		initial_counter_for_new_bbox = 1'b0;
		total_bboxes_first_frame = '0;
		rd_row = '0;
		repeat (2) @(posedge clk);
		reset_N <= 1'b1;
		no_conflict();
		shared_id();
		below_threshold();
		fallback_lost();
		conflict_chain();
		random_frames();
		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
oflow_core_pkg.sv
oflow_cr_pkg.sv
oflow_score_board_if.sv
oflow_lut_ram.sv
oflow_score_board.sv
oflow_conflict_resolve_fsm.sv
oflow_conflict_resolve.sv
oflow_cr_top.sv
oflow_cr_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= oflow_cr_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) oflow_core_config.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(OBJ_DIR)
